/* bench/cpu_testdata.txt */
# run <word count> <cycle limit>, then the program words in hex,
# then the expected values of x0 to x31 in hex
# run 0: alu ops, forwarding, store and load, load-use, ecall halt
run 20 100
00500093 ffd00113 002081b3 40208233
001122b3 fff12313 003093b3 00415413
0ff0c493 00726533 0f017593 00902423
00802603 001606b3 0036d733 00000073
00a00893 00000073 00100793 00100813
00000000 00000005 fffffffd 00000002 00000008 00000001 00000001 00000014
0fffffff 000000fa 0000001c 000000f0 000000fa 000000ff 0000003f 00000000
00000000 0000000a 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
# run 1: beq, bne, blt, bge and jal after a fresh reset
run 21 100
00300093 00300113 00208663 00100193
00100213 00209463 00700293 fff00313
00134663 00100393 00100413 00135463
00c004ef 00100513 00100593 0060d463
00100613 005486b3 00a00893 00000073
00100713
00000000 00000003 00000003 00000000 00000000 00000007 ffffffff 00000000
00000000 00000034 00000000 00000000 00000000 0000003b 00000000 00000000
00000000 0000000a 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000

/* all.f */
rtl/cpu_pkg.sv
rtl/fetch_stage.sv
rtl/register_file.sv
rtl/decode_stage.sv
rtl/hazard_unit.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/cpu_top.sv
bench/cpu_tb.sv

/* bench/cpu_tb.sv */
// testbench for the pipelined cpu
// loads each program from the test data file, runs it to halt, checks the registers
module cpu_tb
    import cpu_pkg::*;
();
    localparam int imem_depth   = 256;
    localparam int period       = 100;
    localparam int drive_delay  = 10;   // inputs change this long after the rising edge
    localparam int reset_cycles = 3;
    localparam int settle       = 4;    // cycles watched after halt

    logic                          clk;
    logic                          reset;
    logic                          prog_we;
    logic [$clog2(imem_depth)-1:0] prog_addr;
    word_t                         prog_data;
    logic                          is_halted;
    word_t                         print_reg [0:31];

    word_t prog_words [$];    // all programs back to back
    word_t expect_regs [$];   // 32 values per run
    int    run_len [$];
    int    run_limit [$];
    int    errors = 0;
    int    watch_cycles = 0;

    cpu_top #(.imem_depth(imem_depth), .dmem_depth(256)) uut (.*);

    initial clk = 1'b0;
    always #(period / 2) clk = ~clk;

    task automatic next_cycle();
        @(posedge clk);
        #drive_delay;
    endtask

    task automatic read_testdata();
        int              fd;
        int              n;
        int              len;
        int              limit;
        word_t           w;
        logic [8*16-1:0] tok;
        logic [8*256-1:0] line;
        fd = $fopen("bench/cpu_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open the test data file");
            errors++;
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                n = $fgets(line, fd);   // rest of a comment line
            end else if (tok == "run") begin
                n = $fscanf(fd, "%d %d", len, limit);
                run_len.push_back(len);
                run_limit.push_back(limit);
                for (int i = 0; i < len + 32; i++) begin
                    n = $fscanf(fd, "%h", w);
                    assert (n == 1) else begin
                        $display("test data ends inside run %0d", run_len.size());
                        errors++;
                    end
                    if (i < len)
                        prog_words.push_back(w);
                    else
                        expect_regs.push_back(w);
                end
            end else begin
                $display("unexpected token in the test data file");
                errors++;
                break;
            end
        end
        $fclose(fd);
    endtask

    // program goes in while reset is high, then reset stays for a few more cycles
    task automatic load_program(int base, int len);
        reset = 1'b1;
        for (int i = 0; i < len; i++) begin
            prog_we   = 1'b1;
            prog_addr = i[$clog2(imem_depth)-1:0];
            prog_data = prog_words[base + i];
            next_cycle();
        end
        prog_we = 1'b0;
        repeat (reset_cycles) next_cycle();
        reset = 1'b0;
    endtask

    task automatic check_after_reset(int r);
        assert (is_halted === 1'b0) else begin
            $display("run %0d: is_halted is high right after reset", r);
            errors++;
        end
        for (int i = 0; i < 32; i++) begin
            assert (print_reg[i] === '0) else begin
                $display("mismatch at %0t: print_reg[%0d] is %h, expected %h after reset",
                         $time, i, print_reg[i], 32'h0);
                errors++;
            end
        end
    endtask

    task automatic run_to_halt(int r, int limit);
        int cycles;
        cycles = 0;
        while (is_halted !== 1'b1 && cycles < limit) begin
            next_cycle();
            cycles++;
        end
        assert (is_halted === 1'b1) else begin
            $display("run %0d: core did not halt within %0d cycles", r, limit);
            errors++;
        end
    endtask

    task automatic check_registers(int r, int base);
        word_t want;
        for (int i = 0; i < 32; i++) begin
            want = expect_regs[base + i];
            assert (print_reg[i] === want) else begin
                $display("mismatch at %0t: print_reg[%0d] is %h, expected %h (run %0d)",
                         $time, i, print_reg[i], want, r);
                errors++;
            end
        end
    endtask

    initial begin
        int word_base;
        int exp_base;
        reset     = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        read_testdata();
        foreach (run_len[r])
            watch_cycles += run_len[r] + reset_cycles + run_limit[r] + settle + 2;
        word_base = 0;
        exp_base  = 0;
        next_cycle();
        foreach (run_len[r]) begin
            load_program(word_base, run_len[r]);
            check_after_reset(r);
            run_to_halt(r, run_limit[r]);
            repeat (settle) next_cycle();   // nothing past the ecall may write
            assert (is_halted === 1'b1) else begin
                $display("run %0d: is_halted dropped after the halt", r);
                errors++;
            end
            check_registers(r, exp_base);
            word_base += run_len[r];
            exp_base  += 32;
        end
        if (run_len.size() == 0) begin
            $display("no runs found in the test data file");
            errors++;
        end
        $display("%0d errors in %0d runs", errors, run_len.size());
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    // watchdog, limit follows from the cycle budgets in the data file
    initial begin
        wait (watch_cycles > 0);
        #(watch_cycles * period);
        $display("watchdog expired after %0d cycles", watch_cycles);
        $display("%0d errors before the timeout", errors);
        $display("Testbench failed");
        $finish;
    end
endmodule

/* rtl/cpu_top.sv */
// cpu top
// five-stage rv32i subset pipeline with program load port and register debug view
module cpu_top
    import cpu_pkg::*;
#(
    parameter int imem_depth = 256,
    parameter int dmem_depth = 256
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          prog_we,
    input  logic [$clog2(imem_depth)-1:0] prog_addr,
    input  word_t                         prog_data,
    output logic                          is_halted,
    output word_t                         print_reg [0:31]
);
    // if/id
    word_t      if_inst;
    word_t      if_pc;
    // decode to hazard unit and fetch
    reg_addr_t  dec_rs1;
    reg_addr_t  dec_rs2;
    logic       is_ecall;
    logic       halt_req;
    // id/ex
    reg_addr_t  id_rs1;
    reg_addr_t  id_rs2;
    reg_addr_t  id_rd;
    word_t      id_rs1_data;
    word_t      id_rs2_data;
    word_t      id_imm;
    word_t      id_pc;
    alu_op_e    id_alu_op;
    logic       id_alu_src;
    logic       id_reg_write;
    logic       id_mem_read;
    logic       id_mem_write;
    logic       id_branch;
    logic       id_jal;
    logic [2:0] id_funct3;
    logic       id_halt;
    // hazard unit
    logic       stall;
    fwd_sel_e   fwd_a;
    fwd_sel_e   fwd_b;
    // ex/mem and redirect
    logic       redirect;
    word_t      redirect_pc;
    word_t      ex_result;
    word_t      ex_store_data;
    reg_addr_t  ex_rd;
    logic       ex_reg_write;
    logic       ex_mem_read;
    logic       ex_mem_write;
    logic       ex_halt;
    // mem/wb
    word_t      mem_fwd_data;
    reg_addr_t  wb_rd;
    word_t      wb_data;
    logic       wb_write;

    // stage ports share their names with the wires above
    fetch_stage #(.imem_depth(imem_depth)) u_fetch (.*);
    decode_stage u_decode (.*);
    hazard_unit u_hazard (.*);
    execute_stage u_execute (.*);
    memory_stage #(.dmem_depth(dmem_depth)) u_memory (.*);
endmodule

/* rtl/memory_stage.sv */
// memory stage
// word-addressed data memory, mem/wb register and the halt flag
module memory_stage
    import cpu_pkg::*;
#(
    parameter int dmem_depth = 256
) (
    input  logic      clk,
    input  logic      reset,
    input  word_t     ex_result,
    input  word_t     ex_store_data,
    input  reg_addr_t ex_rd,
    input  logic      ex_reg_write,
    input  logic      ex_mem_read,
    input  logic      ex_mem_write,
    input  logic      ex_halt,
    output word_t     mem_fwd_data,
    output reg_addr_t wb_rd,
    output word_t     wb_data,
    output logic      wb_write,
    output logic      is_halted
);
    localparam int aw = $clog2(dmem_depth);

    word_t         dmem [dmem_depth];
    logic [aw-1:0] addr;
    logic          wb_halt;   // halting ecall sits in writeback

    assign addr         = ex_result[aw+1:2];
    assign mem_fwd_data = ex_mem_read ? dmem[addr] : ex_result;   // also the wb select

    always_ff @(posedge clk) begin
        if (ex_mem_write)
            dmem[addr] <= ex_store_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_write  <= 1'b0;
            wb_halt   <= 1'b0;
            wb_rd     <= '0;
            is_halted <= 1'b0;
        end else begin
            wb_write <= ex_reg_write;
            wb_halt  <= ex_halt;
            wb_rd    <= ex_rd;
            if (wb_halt)
                is_halted <= 1'b1;   // sticky until reset
        end
    end

    always_ff @(posedge clk) begin
        wb_data <= mem_fwd_data;
    end

    assert property (@(posedge clk) disable iff (reset) !(ex_mem_read && ex_mem_write));
endmodule

/* rtl/execute_stage.sv */
// execute stage
// operand forwarding, alu, branch resolution and the ex/mem register
module execute_stage
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  reg_addr_t  id_rd,
    input  word_t      id_rs1_data,
    input  word_t      id_rs2_data,
    input  word_t      id_imm,
    input  word_t      id_pc,
    input  alu_op_e    id_alu_op,
    input  logic       id_alu_src,
    input  logic       id_reg_write,
    input  logic       id_mem_read,
    input  logic       id_mem_write,
    input  logic       id_branch,
    input  logic       id_jal,
    input  logic [2:0] id_funct3,
    input  logic       id_halt,
    input  fwd_sel_e   fwd_a,
    input  fwd_sel_e   fwd_b,
    input  word_t      mem_fwd_data,
    input  word_t      wb_data,
    output logic       redirect,
    output word_t      redirect_pc,
    output word_t      ex_result,
    output word_t      ex_store_data,
    output reg_addr_t  ex_rd,
    output logic       ex_reg_write,
    output logic       ex_mem_read,
    output logic       ex_mem_write,
    output logic       ex_halt
);
    word_t op_a;
    word_t op_b;       // forwarded rs2, also the store data
    word_t alu_in_b;
    word_t alu_out;
    logic  taken;

    function automatic word_t forward(fwd_sel_e sel, word_t reg_val);
        case (sel)
            fwd_mem: return mem_fwd_data;
            fwd_wb:  return wb_data;
            default: return reg_val;
        endcase
    endfunction

    always_comb begin
        op_a     = forward(fwd_a, id_rs1_data);
        op_b     = forward(fwd_b, id_rs2_data);
        alu_in_b = id_alu_src ? id_imm : op_b;
        case (id_alu_op)
            alu_add: alu_out = op_a + alu_in_b;
            alu_sub: alu_out = op_a - alu_in_b;
            alu_and: alu_out = op_a & alu_in_b;
            alu_or:  alu_out = op_a | alu_in_b;
            alu_xor: alu_out = op_a ^ alu_in_b;
            alu_slt: alu_out = word_t'($signed(op_a) < $signed(alu_in_b));
            alu_sll: alu_out = op_a << alu_in_b[4:0];
            default: alu_out = op_a >> alu_in_b[4:0];   // srl
        endcase
        case (id_funct3)
            3'b000:  taken = (op_a == op_b);                     // beq
            3'b001:  taken = (op_a != op_b);                     // bne
            3'b100:  taken = ($signed(op_a) < $signed(op_b));    // blt
            3'b101:  taken = ($signed(op_a) >= $signed(op_b));   // bge
            default: taken = 1'b0;
        endcase
    end

    // fetch assumed not-taken, so every taken branch or jal redirects
    assign redirect    = (id_branch && taken) || id_jal;
    assign redirect_pc = id_pc + id_imm;

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_halt      <= 1'b0;
            ex_rd        <= '0;
        end else begin
            ex_reg_write <= id_reg_write;
            ex_mem_read  <= id_mem_read;
            ex_mem_write <= id_mem_write;
            ex_halt      <= id_halt;
            ex_rd        <= id_rd;
        end
    end

    always_ff @(posedge clk) begin
        ex_result     <= id_jal ? id_pc + 32'd4 : alu_out;   // jal link value
        ex_store_data <= op_b;
    end

    // redirect flushes id/ex, so the next slot is always a bubble
    assert property (@(posedge clk) disable iff (reset) redirect |=> !redirect);
endmodule

/* rtl/hazard_unit.sv */
// hazard unit
// load-use and ecall stalls, and operand forwarding selects for execute
module hazard_unit
    import cpu_pkg::*;
(
    input  reg_addr_t dec_rs1,
    input  reg_addr_t dec_rs2,
    input  logic      is_ecall,
    input  reg_addr_t id_rd,
    input  logic      id_mem_read,
    input  logic      id_reg_write,
    input  reg_addr_t ex_rd,
    input  logic      ex_reg_write,
    input  reg_addr_t id_rs1,
    input  reg_addr_t id_rs2,
    input  reg_addr_t wb_rd,
    input  logic      wb_write,
    output logic      stall,
    output fwd_sel_e  fwd_a,
    output fwd_sel_e  fwd_b
);
    logic load_use;
    logic ecall_wait;

    // newest producer first, x0 never forwarded
    function automatic fwd_sel_e pick_source(reg_addr_t rs);
        if (ex_reg_write && ex_rd != '0 && ex_rd == rs)
            return fwd_mem;
        if (wb_write && wb_rd != '0 && wb_rd == rs)
            return fwd_wb;
        return fwd_none;
    endfunction

    always_comb begin
        fwd_a = pick_source(id_rs1);
        fwd_b = pick_source(id_rs2);
    end

    assign load_use = id_mem_read && id_rd != '0 && (id_rd == dec_rs1 || id_rd == dec_rs2);

    // ecall reads x17 in decode, so a write in execute or memory must reach wb first
    assign ecall_wait = is_ecall && ((id_reg_write && id_rd == halt_reg) ||
                                     (ex_reg_write && ex_rd == halt_reg));
    assign stall = load_use || ecall_wait;
endmodule

/* rtl/decode_stage.sv */
// decode stage
// opcode decode, immediates, ecall halt test and the id/ex register
module decode_stage
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  word_t      if_inst,
    input  word_t      if_pc,
    input  logic       stall,
    input  logic       redirect,
    input  reg_addr_t  wb_rd,
    input  word_t      wb_data,
    input  logic       wb_write,
    output reg_addr_t  dec_rs1,
    output reg_addr_t  dec_rs2,
    output logic       is_ecall,
    output logic       halt_req,
    output word_t      print_reg [0:31],
    output reg_addr_t  id_rs1,
    output reg_addr_t  id_rs2,
    output reg_addr_t  id_rd,
    output word_t      id_rs1_data,
    output word_t      id_rs2_data,
    output word_t      id_imm,
    output word_t      id_pc,
    output alu_op_e    id_alu_op,
    output logic       id_alu_src,
    output logic       id_reg_write,
    output logic       id_mem_read,
    output logic       id_mem_write,
    output logic       id_branch,
    output logic       id_jal,
    output logic [2:0] id_funct3,
    output logic       id_halt
);
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      imm;
    alu_op_e    alu_op;
    logic       alu_src;
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    logic       branch;
    logic       jal;
    logic       halt_hit;
    logic [2:0] funct3;

    assign funct3  = if_inst[14:12];
    assign dec_rs1 = is_ecall ? halt_reg : if_inst[19:15];   // ecall tests a7
    assign dec_rs2 = if_inst[24:20];

    register_file u_regs (
        .clk       (clk),
        .reset     (reset),
        .rs1       (dec_rs1),
        .rs2       (dec_rs2),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .wb_write  (wb_write),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .print_reg (print_reg)
    );

    always_comb begin
        alu_op    = alu_add;
        alu_src   = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch    = 1'b0;
        jal       = 1'b0;
        is_ecall  = 1'b0;
        imm       = {{20{if_inst[31]}}, if_inst[31:20]};   // i-type
        case (opcode_e'(if_inst[6:0]))
            op_reg, op_imm: begin
                reg_write = 1'b1;
                alu_src   = !if_inst[5];   // bit 5 clear for op_imm
                case (funct3)
                    3'b000:  alu_op = (if_inst[5] && if_inst[30]) ? alu_sub : alu_add;
                    3'b001:  alu_op = alu_sll;
                    3'b010:  alu_op = alu_slt;
                    3'b100:  alu_op = alu_xor;
                    3'b101:  alu_op = alu_srl;
                    3'b110:  alu_op = alu_or;
                    default: alu_op = alu_and;
                endcase
            end
            op_load: begin
                reg_write = 1'b1;
                mem_read  = 1'b1;
                alu_src   = 1'b1;
            end
            op_store: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
                imm       = {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
            end
            op_branch: begin
                branch = 1'b1;
                imm    = {{20{if_inst[31]}}, if_inst[7], if_inst[30:25], if_inst[11:8], 1'b0};
            end
            op_jal: begin
                jal       = 1'b1;
                reg_write = 1'b1;
                imm = {{12{if_inst[31]}}, if_inst[19:12], if_inst[20], if_inst[30:21], 1'b0};
            end
            op_system: is_ecall = 1'b1;
            default: ;
        endcase
    end

    // x17 is only trusted once no write to it is pending
    assign halt_hit = is_ecall && (rs1_data == halt_code);
    assign halt_req = halt_hit && !stall;

    always_ff @(posedge clk) begin
        if (reset || redirect || stall) begin
            id_reg_write <= 1'b0;   // bubble
            id_mem_read  <= 1'b0;
            id_mem_write <= 1'b0;
            id_branch    <= 1'b0;
            id_jal       <= 1'b0;
            id_halt      <= 1'b0;
            id_rd        <= '0;
        end else begin
            id_reg_write <= reg_write;
            id_mem_read  <= mem_read;
            id_mem_write <= mem_write;
            id_branch    <= branch;
            id_jal       <= jal;
            id_halt      <= halt_hit;
            id_rd        <= if_inst[11:7];
        end
    end

    always_ff @(posedge clk) begin
        id_rs1      <= dec_rs1;
        id_rs2      <= dec_rs2;
        id_rs1_data <= rs1_data;
        id_rs2_data <= rs2_data;
        id_imm      <= imm;
        id_pc       <= if_pc;
        id_alu_op   <= alu_op;
        id_alu_src  <= alu_src;
        id_funct3   <= funct3;
    end
endmodule

/* rtl/register_file.sv */
// register file
// 32 x 32 registers, x0 hardwired to zero, writes pass through to the reads
module register_file
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  reg_addr_t wb_rd,
    input  word_t     wb_data,
    input  logic      wb_write,
    output word_t     rs1_data,
    output word_t     rs2_data,
    output word_t     print_reg [0:31]
);
    word_t regs [0:31];
    logic  wr_en;

    assign wr_en = wb_write && (wb_rd != '0);   // x0 ignores writes

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[wb_rd] <= wb_data;
        end
    end

    assign rs1_data  = (wr_en && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rs2_data  = (wr_en && wb_rd == rs2) ? wb_data : regs[rs2];
    assign print_reg = regs;   // debug view
endmodule

/* rtl/fetch_stage.sv */
// fetch stage
// pc, instruction memory with program load port, and the if/id register
module fetch_stage
    import cpu_pkg::*;
#(
    parameter int imem_depth = 256
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          prog_we,
    input  logic [$clog2(imem_depth)-1:0] prog_addr,
    input  word_t                         prog_data,
    input  logic                          stall,
    input  logic                          redirect,
    input  word_t                         redirect_pc,
    input  logic                          halt_req,
    output word_t                         if_inst,
    output word_t                         if_pc
);
    localparam int aw = $clog2(imem_depth);

    word_t imem [imem_depth];
    word_t pc;
    logic  stopped;    // a halting ecall was decoded
    logic  stop_now;

    assign stop_now = stopped || (halt_req && !redirect);

    always_ff @(posedge clk) begin
        if (prog_we)
            imem[prog_addr] <= prog_data;   // loaded while reset is high
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= '0;
            stopped <= 1'b0;
            if_inst <= nop_inst;
            if_pc   <= '0;
        end else if (redirect) begin
            pc      <= redirect_pc;
            if_inst <= nop_inst;            // drop the wrong-path fetch
        end else if (stop_now) begin
            stopped <= 1'b1;
            if_inst <= nop_inst;            // only bubbles after the halt
        end else if (!stall) begin
            pc      <= pc + 32'd4;
            if_inst <= imem[pc[aw+1:2]];
            if_pc   <= pc;
        end
    end

    // sequential fetch and redirect targets keep word alignment
    assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);
endmodule

/* rtl/cpu_pkg.sv */
// cpu package
// shared widths, types and encodings for the rv32i subset pipeline
package cpu_pkg;
    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;   // data, instruction or pc
    typedef logic [4:0]      reg_addr_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_system = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or,
        alu_xor, alu_slt, alu_sll, alu_srl
    } alu_op_e;

    typedef enum logic [1:0] {
        fwd_none,   // register file value from decode
        fwd_mem,    // result held in ex/mem
        fwd_wb      // result held in mem/wb
    } fwd_sel_e;

    localparam word_t nop_inst = 32'h0000_0013;   // addi x0, x0, 0

    // ecall halts when a7 holds 10
    localparam reg_addr_t halt_reg  = 5'd17;
    localparam word_t     halt_code = 32'd10;
endpackage
